// ==== rvv_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Command encodings of the vector unit. Element width values equal
// log2 of the element size in bytes, and the datapath relies on it.
//////////////////////////////////////////////////////////////////////
package rvv_pkg;

  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vew_e;

  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_MACC = 4'd5
  } vop_e;

  typedef enum logic {
    FORM_VV = 1'b0,
    FORM_VI = 1'b1
  } vform_e;

  localparam int unsigned CMD_W = 32;
  localparam int unsigned VS1_W = 3;
  localparam int unsigned IMM_W = 8;

  // Fields shared by both command forms, in the upper bits
  typedef struct packed {
    logic [3:0] id;
    logic [5:0] vl;
    vform_e     form;
    logic [2:0] vs2;
    logic [2:0] vd;
    vew_e       sew;
    vop_e       op;
  } vcmd_hdr_t;

  // Bits left for the form-specific operand
  localparam int unsigned CMD_BODY_W = CMD_W - $bits(vcmd_hdr_t);

  typedef struct packed {
    vcmd_hdr_t               hdr;
    logic [CMD_BODY_W-VS1_W-1:0] pad;
    logic [VS1_W-1:0]        vs1;
  } vcmd_vv_t;

  typedef struct packed {
    vcmd_hdr_t               hdr;
    logic [CMD_BODY_W-IMM_W-1:0] pad;
    logic [IMM_W-1:0]        imm;
  } vcmd_vi_t;

  typedef union packed {
    vcmd_vv_t vv;
    vcmd_vi_t vi;
  } vcmd_t;

endpackage

// ==== vfu_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Geometry and internal transfer types of the vector unit.
// A register-file word spans all lanes, one 32-bit half per lane.
//////////////////////////////////////////////////////////////////////
package vfu_pkg;

  localparam int unsigned N_IPU  = 2;
  localparam int unsigned ELEN   = 32;
  localparam int unsigned ELENB  = ELEN / 8;
  localparam int unsigned VELE   = 4;
  localparam int unsigned N_VREG = 8;
  localparam int unsigned VLMAX  = 32;
  localparam int unsigned VL_W   = $clog2(VLMAX + 1);

  // Wishbone side
  localparam int unsigned WB_AW = 7;
  localparam int unsigned WB_DW = 32;
  localparam logic [WB_AW-1:0] REG_CMD    = 7'd64;
  localparam logic [WB_AW-1:0] REG_STATUS = 7'd65;

  // Register number in the upper bits, word index in the lower
  typedef logic [$clog2(N_VREG*VELE)-1:0] vreg_addr_t;
  typedef logic [N_IPU*ELEN-1:0]          vreg_data_t;
  typedef logic [N_IPU*ELENB-1:0]         vreg_be_t;

  typedef struct packed {
    rvv_pkg::vop_e   op;
    rvv_pkg::vew_e   sew;
    logic [2:0]      vd;
    logic [2:0]      vs1;
    logic [2:0]      vs2;
    logic            use_vs1;
    logic            vd_is_src;
    logic [ELEN-1:0] scalar;
    logic [VL_W-1:0] vl;
    logic [3:0]      id;
  } vfu_req_t;

  typedef struct packed {
    vreg_addr_t addr;
    logic       en;
  } vrf_rd_t;

  typedef struct packed {
    vreg_addr_t addr;
    vreg_data_t data;
    vreg_be_t   be;
    logic       en;
  } vrf_wr_t;

endpackage

// ==== vfu_wb_slave.sv ====
//////////////////////////////////////////////////////////////////////
// Wishbone classic slave, single accesses only, no err or rty.
// Command writes and register-file accesses wait while busy is high.
//////////////////////////////////////////////////////////////////////
module vfu_wb_slave (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [vfu_pkg::WB_AW-1:0]   wb_adr_i,
  input  logic [vfu_pkg::WB_DW-1:0]   wb_dat_i,
  output logic [vfu_pkg::WB_DW-1:0]   wb_dat_o,
  output logic                        wb_ack_o,
  output vfu_pkg::vfu_req_t           req_o,
  output logic                        req_valid_o,
  input  logic                        busy_i,
  input  logic [3:0]                  done_id_i,
  output vfu_pkg::vrf_wr_t            host_req_o,
  input  vfu_pkg::vreg_data_t         host_rdata_i
);
  import rvv_pkg::*;
  import vfu_pkg::*;

  logic     is_rf;
  logic     is_cmd;
  logic     is_status;
  logic     stall;
  logic     go;
  logic     hi_half;
  vcmd_t    cmd;
  vfu_req_t req_d;

  // Words 0..63 map onto the register file, two per entry
  assign is_rf     = ~wb_adr_i[WB_AW-1];
  assign is_cmd    = (wb_adr_i == REG_CMD);
  assign is_status = (wb_adr_i == REG_STATUS);
  assign hi_half   = wb_adr_i[0];

  // Back-pressure while an instruction runs
  assign stall = busy_i & (is_rf | (is_cmd & wb_we_i));
  assign go    = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~stall;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_ack_o    <= 1'b0;
      req_valid_o <= 1'b0;
    end else begin
      wb_ack_o    <= go;
      req_valid_o <= go & is_cmd & wb_we_i;
    end
  end

  /////////////////////////////////////////////////////////////////////
  // Command decode
  /////////////////////////////////////////////////////////////////////

  always_comb begin
    cmd             = wb_dat_i;
    req_d           = '0;
    req_d.op        = cmd.vv.hdr.op;
    req_d.sew       = cmd.vv.hdr.sew;
    req_d.vd        = cmd.vv.hdr.vd;
    req_d.vs2       = cmd.vv.hdr.vs2;
    req_d.vs1       = cmd.vv.vs1;
    req_d.vl        = cmd.vv.hdr.vl;
    req_d.id        = cmd.vv.hdr.id;
    req_d.use_vs1   = (cmd.vv.hdr.form == FORM_VV);
    req_d.vd_is_src = (cmd.vv.hdr.op == OP_MACC);
    // Immediate sign-extended to the element, then replicated
    unique case (cmd.vi.hdr.sew)
      EW_8:    req_d.scalar = {4{cmd.vi.imm}};
      EW_16:   req_d.scalar = {2{{8{cmd.vi.imm[7]}}, cmd.vi.imm}};
      default: req_d.scalar = {{24{cmd.vi.imm[7]}}, cmd.vi.imm};
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (go & is_cmd & wb_we_i) begin
      req_o <= req_d;
    end
  end

  /////////////////////////////////////////////////////////////////////
  // Register-file and status access
  /////////////////////////////////////////////////////////////////////

  // A zero byte enable marks a read
  always_comb begin
    host_req_o      = '0;
    host_req_o.addr = wb_adr_i[WB_AW-2:1];
    host_req_o.data = {N_IPU{wb_dat_i}};
    host_req_o.be   = {{ELENB{hi_half}}, {ELENB{~hi_half}}} & {N_IPU*ELENB{wb_we_i}};
    host_req_o.en   = go & is_rf;
  end

  always_comb begin
    wb_dat_o = '0;
    if (is_rf) begin
      wb_dat_o = hi_half ? host_rdata_i[2*ELEN-1:ELEN] : host_rdata_i[ELEN-1:0];
    end else if (is_status) begin
      wb_dat_o = {{(WB_DW-8){1'b0}}, done_id_i, 3'b000, busy_i};
    end
  end

  a_ack_in_cycle : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(wb_ack_o) |-> wb_cyc_i && wb_stb_i)
    else $error("ack raised outside a bus cycle");

endmodule

// ==== vfu_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// Sequences one instruction at a time, one element group per cycle.
// vl must fit the register at the chosen element width, as the word
// index is not checked against the register boundary.
//////////////////////////////////////////////////////////////////////
module vfu_ctrl (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  vfu_pkg::vfu_req_t                             req_i,
  input  logic                                          req_valid_i,
  output logic                                          busy_o,
  output logic [3:0]                                    done_id_o,
  output vfu_pkg::vrf_rd_t [2:0]                        rd_o,
  input  vfu_pkg::vreg_data_t [2:0]                     rdata_i,
  input  logic [2:0]                                    rvalid_i,
  output vfu_pkg::vrf_wr_t                              wr_o,
  output rvv_pkg::vop_e                                 lane_op_o,
  output rvv_pkg::vew_e                                 lane_sew_o,
  output logic [vfu_pkg::N_IPU-1:0][vfu_pkg::ELEN-1:0]  lane_a_o,
  output logic [vfu_pkg::N_IPU-1:0][vfu_pkg::ELEN-1:0]  lane_b_o,
  output logic [vfu_pkg::N_IPU-1:0][vfu_pkg::ELEN-1:0]  lane_d_o,
  input  logic [vfu_pkg::N_IPU-1:0][vfu_pkg::ELEN-1:0]  lane_res_i
);
  import vfu_pkg::*;

  localparam int unsigned GRP_BYTES = N_IPU * ELENB;
  localparam int unsigned IDX_W     = $clog2(VELE);

  vfu_req_t         req_q;
  logic             busy_q;
  logic [3:0]       done_id_q;
  logic [VL_W-1:0]  rem_q;
  logic [IDX_W-1:0] idx_q;
  logic [3:0]       grp_elems;
  logic [3:0]       act_elems;
  logic [3:0]       act_bytes;
  logic             last_grp;
  logic             rd_active;
  logic             finish;
  vreg_be_t         tail_be;

  // Execute stage
  vreg_addr_t       ex_addr_q;
  logic             ex_last_q;
  vreg_be_t         ex_be_q;

  /////////////////////////////////////////////////////////////////////
  // Group sequencing
  /////////////////////////////////////////////////////////////////////

  // Element count per group shrinks with the element width
  assign grp_elems = 4'(GRP_BYTES >> req_q.sew);
  assign last_grp  = (rem_q <= VL_W'(grp_elems));
  assign act_elems = last_grp ? rem_q[3:0] : grp_elems;
  assign act_bytes = act_elems << req_q.sew;
  assign tail_be   = ~(vreg_be_t'('1) << act_bytes);

  assign rd_active = busy_q & (rem_q != '0);
  // vl = 0 finishes without any group
  assign finish    = (wr_o.en & ex_last_q) | (busy_q & (req_q.vl == '0));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      done_id_q <= '0;
      rem_q     <= '0;
      idx_q     <= '0;
      ex_last_q <= 1'b0;
    end else begin
      ex_last_q <= rd_active & last_grp;
      if (req_valid_i) begin
        busy_q <= 1'b1;
        rem_q  <= req_i.vl;
        idx_q  <= '0;
      end else begin
        if (rd_active) begin
          rem_q <= last_grp ? '0 : rem_q - VL_W'(grp_elems);
          idx_q <= idx_q + 1'b1;
        end
        if (finish) begin
          busy_q    <= 1'b0;
          done_id_q <= req_q.id;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      req_q <= req_i;
    end
    if (rd_active) begin
      ex_addr_q <= {req_q.vd, idx_q};
      ex_be_q   <= tail_be;
    end
  end

  assign busy_o    = busy_q;
  assign done_id_o = done_id_q;

  /////////////////////////////////////////////////////////////////////
  // Operand read and write-back
  /////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_o[0].addr = {req_q.vs2, idx_q};
    rd_o[0].en   = rd_active;
    rd_o[1].addr = {req_q.vs1, idx_q};
    rd_o[1].en   = rd_active & req_q.use_vs1;
    rd_o[2].addr = {req_q.vd, idx_q};
    rd_o[2].en   = rd_active & req_q.vd_is_src;
  end

  assign lane_op_o  = req_q.op;
  assign lane_sew_o = req_q.sew;
  assign lane_a_o   = rdata_i[0];
  assign lane_b_o   = rvalid_i[1] ? rdata_i[1] : {N_IPU{req_q.scalar}};
  assign lane_d_o   = rvalid_i[2] ? rdata_i[2] : '0;

  // vs2 is read for every group, so its valid marks the write
  assign wr_o.addr = ex_addr_q;
  assign wr_o.data = lane_res_i;
  assign wr_o.be   = ex_be_q;
  assign wr_o.en   = rvalid_i[0];

  a_no_req_busy : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i |-> !busy_o)
    else $error("command accepted while busy");

endmodule

// ==== vfu_ipu.sv ====
//////////////////////////////////////////////////////////////////////
// One 32-bit integer lane, purely combinational.
// Subtraction is vs2 - vs1; multiply-accumulate keeps the low bits.
//////////////////////////////////////////////////////////////////////
module vfu_ipu (
  input  rvv_pkg::vop_e              op_i,
  input  rvv_pkg::vew_e              sew_i,
  input  logic [vfu_pkg::ELEN-1:0]   op_a_i,
  input  logic [vfu_pkg::ELEN-1:0]   op_b_i,
  input  logic [vfu_pkg::ELEN-1:0]   op_d_i,
  output logic [vfu_pkg::ELEN-1:0]   result_o
);
  import rvv_pkg::*;
  import vfu_pkg::*;

  // Low bits of a wide result are exact for any narrower element
  function automatic logic [ELEN-1:0] elem_op(vop_e op, logic [ELEN-1:0] a,
                                               logic [ELEN-1:0] b, logic [ELEN-1:0] d);
    unique case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_MACC: return d + a * b;
      default: return '0;
    endcase
  endfunction

  logic [ELENB-1:0][7:0]     res8;
  logic [ELENB/2-1:0][15:0]  res16;
  logic [ELEN-1:0]           res32;

  // Each element is computed on its own slice, so no carry crosses over
  always_comb begin
    for (int i = 0; i < ELENB; i++) begin
      res8[i] = 8'(elem_op(op_i, ELEN'(op_a_i[8*i +: 8]), ELEN'(op_b_i[8*i +: 8]),
                           ELEN'(op_d_i[8*i +: 8])));
    end
    for (int i = 0; i < ELENB/2; i++) begin
      res16[i] = 16'(elem_op(op_i, ELEN'(op_a_i[16*i +: 16]), ELEN'(op_b_i[16*i +: 16]),
                             ELEN'(op_d_i[16*i +: 16])));
    end
    res32 = elem_op(op_i, op_a_i, op_b_i, op_d_i);
  end

  always_comb begin
    unique case (sew_i)
      EW_8:    result_o = res8;
      EW_16:   result_o = res16;
      default: result_o = res32;
    endcase
  end

endmodule

// ==== vfu_vrf.sv ====
//////////////////////////////////////////////////////////////////////
// Vector register file, 8 registers of 4 words, 64 bits per word.
// Reads are registered; a read and a write of one word in the same
// cycle return the old contents.
//////////////////////////////////////////////////////////////////////
module vfu_vrf (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  vfu_pkg::vrf_rd_t [2:0]      rd_i,
  output vfu_pkg::vreg_data_t [2:0]   rdata_o,
  output logic [2:0]                  rvalid_o,
  input  vfu_pkg::vrf_wr_t            wr_i,
  input  vfu_pkg::vrf_wr_t            host_req_i,
  output vfu_pkg::vreg_data_t         host_rdata_o
);
  import vfu_pkg::*;

  localparam int unsigned N_WORDS = N_VREG * VELE;

  vreg_data_t mem [N_WORDS];
  vrf_wr_t    wport;
  logic       host_wr;

  // Host access with any byte enable set is a write
  assign host_wr = host_req_i.en & (|host_req_i.be);

  /////////////////////////////////////////////////////////////////////
  // Shared write path
  /////////////////////////////////////////////////////////////////////

  always_comb begin
    wport = wr_i;
    if (!wr_i.en) begin
      wport    = host_req_i;
      wport.en = host_wr;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < N_IPU*ELENB; b++) begin
      if (wport.en && wport.be[b]) begin
        mem[wport.addr][8*b +: 8] <= wport.data[8*b +: 8];
      end
    end
  end

  /////////////////////////////////////////////////////////////////////
  // Read ports
  /////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_o <= '0;
    end else begin
      for (int p = 0; p < 3; p++) begin
        rvalid_o[p] <= rd_i[p].en;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int p = 0; p < 3; p++) begin
      if (rd_i[p].en) begin
        rdata_o[p] <= mem[rd_i[p].addr];
      end
    end
    if (host_req_i.en) begin
      host_rdata_o <= mem[host_req_i.addr];
    end
  end

  a_one_writer : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(host_wr && wr_i.en))
    else $error("host and controller write in the same cycle");

endmodule

// ==== vfu_top.sv ====
//////////////////////////////////////////////////////////////////////
// SIMD vector unit behind a Wishbone classic slave port.
// Only whole-word writes are supported, so sel must be all ones.
//////////////////////////////////////////////////////////////////////
module vfu_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [vfu_pkg::WB_AW-1:0]     wb_adr_i,
  input  logic [vfu_pkg::WB_DW-1:0]     wb_dat_i,
  input  logic [vfu_pkg::WB_DW/8-1:0]   wb_sel_i,
  output logic [vfu_pkg::WB_DW-1:0]     wb_dat_o,
  output logic                          wb_ack_o
);
  import rvv_pkg::*;
  import vfu_pkg::*;

  vfu_req_t                    req;
  logic                        req_valid;
  logic                        busy;
  logic [3:0]                  done_id;
  vrf_wr_t                     host_req;
  vreg_data_t                  host_rdata;
  vrf_rd_t [2:0]               vrf_rd;
  vreg_data_t [2:0]            vrf_rdata;
  logic [2:0]                  vrf_rvalid;
  vrf_wr_t                     vrf_wr;
  vop_e                        lane_op;
  vew_e                        lane_sew;
  logic [N_IPU-1:0][ELEN-1:0]  lane_a;
  logic [N_IPU-1:0][ELEN-1:0]  lane_b;
  logic [N_IPU-1:0][ELEN-1:0]  lane_d;
  logic [N_IPU-1:0][ELEN-1:0]  lane_res;

  vfu_wb_slave u_wb_slave (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .req_o        (req),
    .req_valid_o  (req_valid),
    .busy_i       (busy),
    .done_id_i    (done_id),
    .host_req_o   (host_req),
    .host_rdata_i (host_rdata)
  );

  vfu_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req),
    .req_valid_i (req_valid),
    .busy_o      (busy),
    .done_id_o   (done_id),
    .rd_o        (vrf_rd),
    .rdata_i     (vrf_rdata),
    .rvalid_i    (vrf_rvalid),
    .wr_o        (vrf_wr),
    .lane_op_o   (lane_op),
    .lane_sew_o  (lane_sew),
    .lane_a_o    (lane_a),
    .lane_b_o    (lane_b),
    .lane_d_o    (lane_d),
    .lane_res_i  (lane_res)
  );

  vfu_vrf u_vrf (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_i         (vrf_rd),
    .rdata_o      (vrf_rdata),
    .rvalid_o     (vrf_rvalid),
    .wr_i         (vrf_wr),
    .host_req_i   (host_req),
    .host_rdata_o (host_rdata)
  );

  // Lane i works on bits 32*i and up of each register-file word
  for (genvar i = 0; i < N_IPU; i++) begin : gen_ipu
    vfu_ipu u_ipu (
      .op_i     (lane_op),
      .sew_i    (lane_sew),
      .op_a_i   (lane_a[i]),
      .op_b_i   (lane_b[i]),
      .op_d_i   (lane_d[i]),
      .result_o (lane_res[i])
    );
  end

  a_full_word_write : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_cyc_i && wb_stb_i && wb_we_i |-> wb_sel_i == '1)
    else $error("partial word write on the bus");

endmodule

// ==== tb_clkgen.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench clock and reset, 8 ns period.
// Reset is held low for 4 cycles and released on a falling edge.
//////////////////////////////////////////////////////////////////////
module tb_clkgen (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RST_CYCLES = 4;

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== tb_vfu.sv ====
//////////////////////////////////////////////////////////////////////
// Runs an instruction table through the vector unit over Wishbone and
// compares vd with a byte-level reference model. Entries marked chain
// are issued right behind the previous command while it is busy.
//////////////////////////////////////////////////////////////////////
module tb_vfu;
  timeunit 1ns;
  timeprecision 100ps;

  import rvv_pkg::*;

  localparam int N_INSTR = 12;
  localparam int POLLS   = 6;
  // Register-file load and read-back, then command, polls and vd read-back
  localparam int N_ACC   = 128 + N_INSTR * (9 + POLLS);
  localparam int LIMIT   = 20 * N_ACC + 10 * N_INSTR;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [6:0]  adr;
    logic [31:0] dat;
    logic [3:0]  sel;
  } wb_req_t;

  typedef struct packed {
    vop_e             op;
    vew_e             sew;
    logic             vi;
    logic [2:0]       vd;
    logic [2:0]       vs2;
    logic [2:0]       vs1;
    logic [7:0]       imm;
    logic [5:0]       vl;
    logic [3:0]       id;
    logic             chain;
    logic [3:0][63:0] exp_vd;
  } entry_t;

  logic        clk;
  logic        rst_n;
  wb_req_t     host;
  logic [31:0] wb_rdata;
  logic        wb_ack;
  int          seed;
  int          cycles = 0;
  entry_t      tbl [N_INSTR];
  logic [31:0] init_mem [64];
  logic [7:0]  ref_rf [8][32];

  tb_clkgen u_clkgen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  vfu_top u_vfu_top (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .wb_cyc_i (host.cyc),
    .wb_stb_i (host.stb),
    .wb_we_i  (host.we),
    .wb_adr_i (host.adr),
    .wb_dat_i (host.dat),
    .wb_sel_i (host.sel),
    .wb_dat_o (wb_rdata),
    .wb_ack_o (wb_ack)
  );

  task automatic end_with_failure();
    $display("Done: errors found");
    $fatal(1, "Simulation stopped");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > LIMIT) begin
      $display("Timeout: the run took more than %0d cycles", LIMIT);
      end_with_failure();
    end
  end

  task automatic check_val(string name, logic [31:0] got, logic [31:0] expv);
    assert (got === expv)
    else begin
      $display("** Error: %s expected %h, got %h", name, expv, got);
      end_with_failure();
    end
  endtask

  /////////////////////////////////////////////////////////////////////
  // Reference model
  /////////////////////////////////////////////////////////////////////

  function automatic entry_t make_entry(vop_e op, vew_e sew, int vi, int vd, int vs2,
                                        int vs1, int imm, int vl, int id, int chain);
    entry_t e;
    e       = '0;
    e.op    = op;
    e.sew   = sew;
    e.vi    = 1'(vi);
    e.vd    = 3'(vd);
    e.vs2   = 3'(vs2);
    e.vs1   = 3'(vs1);
    e.imm   = 8'(imm);
    e.vl    = 6'(vl);
    e.id    = 4'(id);
    e.chain = 1'(chain);
    return e;
  endfunction

  // Element e of a register, nb bytes wide, zero-extended
  function automatic logic [31:0] get_elem(logic [2:0] r, int e, int nb);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < nb; k++) begin
      v[8*k +: 8] = ref_rf[r][e*nb + k];
    end
    return v;
  endfunction

  task automatic apply_ref(int i);
    int          nb;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] d;
    logic [31:0] r;
    logic [31:0] simm;
    nb   = 1 << int'(tbl[i].sew);
    simm = {{24{tbl[i].imm[7]}}, tbl[i].imm};
    for (int e = 0; e < int'(tbl[i].vl); e++) begin
      a = get_elem(tbl[i].vs2, e, nb);
      b = tbl[i].vi ? simm : get_elem(tbl[i].vs1, e, nb);
      d = get_elem(tbl[i].vd, e, nb);
      case (tbl[i].op)
        OP_ADD:  r = a + b;
        OP_SUB:  r = a - b;
        OP_AND:  r = a & b;
        OP_OR:   r = a | b;
        OP_XOR:  r = a ^ b;
        OP_MACC: r = d + a * b;
        default: r = '0;
      endcase
      // Only the element's own bytes are written, which drops any carry out
      for (int k = 0; k < nb; k++) begin
        ref_rf[tbl[i].vd][e*nb + k] = r[8*k +: 8];
      end
    end
    for (int w = 0; w < 4; w++) begin
      for (int k = 0; k < 8; k++) begin
        tbl[i].exp_vd[w][8*k +: 8] = ref_rf[tbl[i].vd][8*w + k];
      end
    end
  endtask

  // Command layout: id, vl, form, vs2, vd, sew, op, then vs1 or imm
  function automatic logic [31:0] cmd_word(entry_t e);
    logic [31:0] w;
    w        = '0;
    w[31:28] = e.id;
    w[27:22] = e.vl;
    w[21]    = e.vi;
    w[20:18] = e.vs2;
    w[17:15] = e.vd;
    w[14:13] = e.sew;
    w[12:9]  = e.op;
    w[7:0]   = e.vi ? e.imm : {5'd0, e.vs1};
    return w;
  endfunction

  /////////////////////////////////////////////////////////////////////
  // Bus tasks
  /////////////////////////////////////////////////////////////////////

  task automatic bus_access(logic we, logic [6:0] adr, logic [31:0] wdat,
                            output logic [31:0] rdat);
    @(negedge clk);
    host.cyc = 1'b1;
    host.stb = 1'b1;
    host.we  = we;
    host.adr = adr;
    host.dat = wdat;
    host.sel = 4'hf;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    rdat     = wb_rdata;
    // Request stays up across the clock edge that samples ack
    @(negedge clk);
    host.cyc = 1'b0;
    host.stb = 1'b0;
    host.we  = 1'b0;
  endtask

  task automatic issue_cmd(int i);
    logic [31:0] rd;
    bus_access(1'b1, vfu_pkg::REG_CMD, cmd_word(tbl[i]), rd);
  endtask

  // Busy must show on the first poll unless vl is 0
  task automatic wait_done(int i, logic [3:0] prev_id);
    logic [31:0] st;
    bus_access(1'b0, vfu_pkg::REG_STATUS, '0, st);
    if (tbl[i].vl != '0) begin
      check_val("status.busy", {31'd0, st[0]}, 32'd1);
    end
    while (st[0]) begin
      check_val("status.done_id", {28'd0, st[7:4]}, {28'd0, prev_id});
      bus_access(1'b0, vfu_pkg::REG_STATUS, '0, st);
    end
    check_val("status.done_id", {28'd0, st[7:4]}, {28'd0, tbl[i].id});
  endtask

  task automatic check_vd(int i);
    logic [31:0] rd;
    logic [6:0]  adr;
    for (int j = 0; j < 8; j++) begin
      adr = 7'(int'(tbl[i].vd) * 8 + j);
      bus_access(1'b0, adr, '0, rd);
      check_val($sformatf("wb_dat_o at adr %h", adr), rd,
                tbl[i].exp_vd[j / 2][32 * (j % 2) +: 32]);
    end
  endtask

  /////////////////////////////////////////////////////////////////////
  // Stimulus
  /////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    logic [3:0]  last_id;
    int          i;
    host = '0;
    seed = 66;
    for (int a = 0; a < 64; a++) begin
      init_mem[a] = $random(seed);
      for (int k = 0; k < 4; k++) begin
        ref_rf[a / 8][(a % 8) * 4 + k] = init_mem[a][8*k +: 8];
      end
    end

    //                    op       sew    vi vd vs2 vs1 imm   vl id chain
    tbl[0]  = make_entry(OP_ADD,  EW_8,  0, 2, 0, 1, 0,    32, 1,  0);
    tbl[1]  = make_entry(OP_SUB,  EW_16, 0, 3, 1, 0, 0,    16, 2,  0);
    tbl[2]  = make_entry(OP_AND,  EW_32, 0, 4, 2, 3, 0,    8,  3,  0);
    tbl[3]  = make_entry(OP_OR,   EW_8,  0, 5, 3, 4, 0,    32, 4,  0);
    tbl[4]  = make_entry(OP_XOR,  EW_16, 0, 6, 4, 5, 0,    16, 5,  0);
    tbl[5]  = make_entry(OP_ADD,  EW_8,  1, 7, 6, 0, -3,   32, 6,  0);
    tbl[6]  = make_entry(OP_SUB,  EW_32, 1, 0, 7, 0, -128, 8,  7,  0);
    tbl[7]  = make_entry(OP_MACC, EW_16, 0, 1, 2, 3, 0,    5,  8,  0);
    tbl[8]  = make_entry(OP_MACC, EW_32, 1, 2, 5, 0, -7,   3,  9,  0);
    tbl[9]  = make_entry(OP_XOR,  EW_8,  0, 3, 0, 6, 0,    0,  10, 0);
    tbl[10] = make_entry(OP_ADD,  EW_32, 0, 4, 6, 1, 0,    8,  11, 0);
    tbl[11] = make_entry(OP_MACC, EW_8,  0, 5, 7, 0, 0,    21, 12, 1);
    for (int t = 0; t < N_INSTR; t++) begin
      apply_ref(t);
    end

    wait (rst_n === 1'b1);
    for (int a = 0; a < 64; a++) begin
      bus_access(1'b1, 7'(a), init_mem[a], rd);
    end
    for (int a = 0; a < 64; a++) begin
      bus_access(1'b0, 7'(a), '0, rd);
      check_val($sformatf("wb_dat_o at adr %h", 7'(a)), rd, init_mem[a]);
    end

    i       = 0;
    last_id = '0;
    while (i < N_INSTR) begin
      issue_cmd(i);
      if (i + 1 < N_INSTR && tbl[i + 1].chain) begin
        // Second command stalls on the bus until the first one ends
        issue_cmd(i + 1);
        wait_done(i + 1, tbl[i].id);
        check_vd(i);
        check_vd(i + 1);
        last_id = tbl[i + 1].id;
        i       = i + 2;
      end else begin
        wait_done(i, last_id);
        check_vd(i);
        last_id = tbl[i].id;
        i       = i + 1;
      end
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== all.f ====
rvv_pkg.sv
vfu_pkg.sv
vfu_wb_slave.sv
vfu_ctrl.sv
vfu_ipu.sv
vfu_vrf.sv
vfu_top.sv
tb_clkgen.sv
tb_vfu.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module tb_vfu -o sim_vfu \
  && ./obj_dir/sim_vfu || exit 1
